/* mem_stage_top.f */
+incdir+design
design/mem_access_pkg.sv
design/axi_lite_pkg.sv
design/load_align.sv
design/axi_lite_sram.sv
design/memu.sv
design/mem_stage_top.sv
tests/mem_stage_properties.sv
tests/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - include_dirs:
      - design
    files:
      - design/mem_access_pkg.sv
      - design/axi_lite_pkg.sv
      - design/load_align.sv
      - design/axi_lite_sram.sv
      - design/memu.sv
      - design/mem_stage_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/mem_stage_properties.sv
      - tests/mem_stage_tb.sv

/* tests/mem_stage_tb.sv */
// memory stage testbench
`timescale 1ns/1ps
`include "memu_config.svh"

module mem_stage_tb;

	localparam int AW           = `MEMU_ADDR_WIDTH;
	localparam int DW           = `MEMU_DATA_WIDTH;
	localparam int IDX_W        = $clog2(`MEMU_SRAM_WORDS);
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 4;

	localparam int WORDS           = 16;
	localparam int NARROW_STORES   = 24;
	localparam int LOAD_REPS       = 2;
	localparam int NOOP_COUNT      = 4;
	localparam int RANDOM_REQUESTS = 60;
	localparam int NUM_REQUESTS    = 2 * WORDS + NARROW_STORES + WORDS + 12 * LOAD_REPS
		+ 2 * NOOP_COUNT + RANDOM_REQUESTS;

	// four sram waits, fixed fsm phases, longest out_ready stall
	localparam int FIXED_PHASES  = 8;
	localparam int MAX_STALL     = 7;
	localparam int WORST_LATENCY = 4 * `MEMU_SRAM_WAIT + FIXED_PHASES + MAX_STALL;
	localparam int ACCEPT_LIMIT  = 2 * WORST_LATENCY;
	localparam int WATCHDOG_NS   = NUM_REQUESTS * WORST_LATENCY * CLK_PERIOD * 2;

	localparam logic [31:0] LFSR_SEED = 32'h2f72;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                     clk;
	logic                     reset;
	logic                     in_valid;
	logic                     in_ready;
	mem_access_pkg::mem_op_e  op;
	logic [AW-1:0]            addr;
	logic [DW-1:0]            wdata;
	mem_access_pkg::mem_ctl_u ctl;
	logic                     out_valid;
	logic                     out_ready;
	logic [DW-1:0]            out_rdata;

	logic [7:0]    model_bytes [0:`MEMU_SRAM_WORDS*4-1];
	logic [DW-1:0] expected_q [$];
	logic [31:0]   stim_lfsr = LFSR_SEED;
	logic [31:0]   stall_lfsr = LFSR_SEED;
	logic          stall_enable;
	int            stall_left = 0;
	string         cur_test;
	int            test_errors;
	int            total_errors = 0;
	int            tests_run = 0;
	int            tests_failed = 0;
	int            requests_accepted = 0;
	int            results_seen = 0;

	mem_stage_top UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.ctl       (ctl),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rdata (out_rdata)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	function logic [31:0] stim_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return v;
	endfunction

	// separate stream so stalls do not depend on request order
	function logic [31:0] stall_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stall_lfsr[0]};
			stall_lfsr = lfsr_step(stall_lfsr);
		end
		return v;
	endfunction

	// upper bits random, the sram ignores them
	function automatic logic [AW-1:0] make_addr(input logic [3:0] idx, input logic [1:0] off);
		logic [31:0] upper;
		upper = stim_bits(AW - 10);
		return {upper[AW-11:0], 4'b0000, idx, off};
	endfunction

	function automatic mem_access_pkg::mem_ctl_u store_ctl(input int nbytes);
		mem_access_pkg::mem_ctl_u c;
		c.mask = (nbytes == 4) ? 4'b1111 : (nbytes == 2) ? 4'b0011 : 4'b0001;
		return c;
	endfunction

	function automatic mem_access_pkg::mem_ctl_u load_ctl(
		input mem_access_pkg::load_size_e size,
		input logic                       uns
	);
		mem_access_pkg::mem_ctl_u c;
		c.load.is_unsigned = uns;
		c.load.size        = size;
		c.load.pad         = 1'b0;
		return c;
	endfunction

	task automatic store_model(
		input logic [AW-1:0]            a,
		input logic [DW-1:0]            d,
		input mem_access_pkg::mem_ctl_u c
	);
		logic [3:0] lanes;
		int         base;
		int         off;
		base  = int'(a[IDX_W+1:2]) * 4;
		off   = int'(a[1:0]);
		lanes = c.mask << off;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) begin
				model_bytes[base + i] = d[(i - off) * 8 +: 8];
			end
		end
	endtask

	function automatic logic [DW-1:0] load_model(
		input logic [AW-1:0]            a,
		input mem_access_pkg::mem_ctl_u c
	);
		logic [7:0]  b;
		logic [15:0] h;
		int          base;
		int          off;
		base = int'(a[IDX_W+1:2]) * 4;
		off  = int'(a[1:0]);
		case (c.load.size)
			mem_access_pkg::SIZE_BYTE: begin
				b = model_bytes[base + off];
				if (c.load.is_unsigned) begin
					return {24'b0, b};
				end
				return {{24{b[7]}}, b};
			end
			mem_access_pkg::SIZE_HALF: begin
				h = {model_bytes[base + off + 1], model_bytes[base + off]};
				if (c.load.is_unsigned) begin
					return {16'b0, h};
				end
				return {{16{h[15]}}, h};
			end
			default: begin
				return {model_bytes[base + 3], model_bytes[base + 2],
					model_bytes[base + 1], model_bytes[base]};
			end
		endcase
	endfunction

	task automatic note_error();
		test_errors++;
		total_errors++;
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, test_errors);
		end
	endtask

	// drive one request and record its expected result at acceptance
	task automatic issue(
		input mem_access_pkg::mem_op_e  o,
		input logic [AW-1:0]            a,
		input logic [DW-1:0]            d,
		input mem_access_pkg::mem_ctl_u c
	);
		int            waited;
		logic [DW-1:0] expected;
		logic [31:0]   junk;
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		op       = o;
		addr     = a;
		wdata    = d;
		ctl      = c;
		waited   = 0;
		while (!in_ready && waited < ACCEPT_LIMIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		assert (in_ready) else begin
			$display("%s: request was not accepted within %0d cycles", cur_test, ACCEPT_LIMIT);
			note_error();
		end
		if (in_ready) begin
			assert (expected_q.size() == 0) else begin
				$display("%s: request accepted while a result was still pending", cur_test);
				note_error();
			end
			if (o == mem_access_pkg::MEM_STORE) begin
				store_model(a, d, c);
				expected = '0;
			end else if (o == mem_access_pkg::MEM_LOAD) begin
				expected = load_model(a, c);
			end else begin
				expected = '0;
			end
			expected_q.push_back(expected);
			requests_accepted++;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;
		// garbage on the inputs once the request is locked
		junk  = stim_bits(32);
		addr  = junk;
		wdata = ~junk;
		ctl   = junk[3:0];
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while ((expected_q.size() > 0 || out_valid) && cycles < ACCEPT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (expected_q.size() == 0 && !out_valid) else begin
			$display("%s: results still outstanding after %0d cycles", cur_test, ACCEPT_LIMIT);
			note_error();
		end
	endtask

	task automatic random_request();
		logic [31:0]                sel;
		logic [31:0]                sz;
		logic [31:0]                r;
		logic [31:0]                idx;
		logic [31:0]                uns;
		logic [1:0]                 off;
		int                         nbytes;
		mem_access_pkg::load_size_e size;
		logic [AW-1:0]              a;
		sel = stim_bits(2);
		sz  = stim_bits(2);
		r   = stim_bits(2);
		idx = stim_bits(4);
		uns = stim_bits(1);
		if (sz == 0) begin
			size   = mem_access_pkg::SIZE_BYTE;
			nbytes = 1;
			off    = r[1:0];
		end else if (sz == 1) begin
			size   = mem_access_pkg::SIZE_HALF;
			nbytes = 2;
			off    = {r[1], 1'b0};
		end else begin
			size   = mem_access_pkg::SIZE_WORD;
			nbytes = 4;
			off    = 2'd0;
		end
		a = make_addr(idx[3:0], off);
		if (sel == 0) begin
			issue(mem_access_pkg::MEM_NONE, a, stim_bits(32), store_ctl(4));
		end else if (sel == 1) begin
			issue(mem_access_pkg::MEM_LOAD, a, stim_bits(32), load_ctl(size, uns[0]));
		end else begin
			issue(mem_access_pkg::MEM_STORE, a, stim_bits(32), store_ctl(nbytes));
		end
	endtask

	// back-pressure, stalls bounded by MAX_STALL
	always @(posedge clk) begin
		#1;
		if (!stall_enable) begin
			out_ready = 1'b1;
		end else if (stall_left > 0) begin
			out_ready  = 1'b0;
			stall_left = stall_left - 1;
		end else begin
			out_ready  = 1'b1;
			stall_left = int'(stall_bits(3));
		end
	end

	// result transfers at the next edge when both are high here
	always @(negedge clk) begin
		logic [DW-1:0] exp_value;
		if (!reset && out_valid && out_ready) begin
			results_seen++;
			assert (expected_q.size() > 0) else begin
				$display("%s: a result came out with no request pending", cur_test);
				note_error();
			end
			if (expected_q.size() > 0) begin
				exp_value = expected_q.pop_front();
				assert (out_rdata === exp_value) else begin
					$display("MISMATCH %s expected %h actual %h", cur_test, exp_value, out_rdata);
					note_error();
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with the run unfinished", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] idx;
		logic [AW-1:0] a;
		int          res_start;
		int          req_start;
		clk          = 1'b0;
		reset        = 1'b1;
		in_valid     = 1'b0;
		op           = mem_access_pkg::MEM_NONE;
		addr         = '0;
		wdata        = '0;
		ctl          = '0;
		out_ready    = 1'b1;
		stall_enable = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		start_test("reset_state");
		@(negedge clk);
		assert (in_ready === 1'b1) else begin
			$display("%s: in_ready is not high after reset", cur_test);
			note_error();
		end
		assert (out_valid === 1'b0) else begin
			$display("%s: out_valid is not low after reset", cur_test);
			note_error();
		end
		finish_test();

		// also fills the region that later tests use
		start_test("word_store_load");
		for (int i = 0; i < WORDS; i++) begin
			issue(mem_access_pkg::MEM_STORE, make_addr(i[3:0], 2'd0), stim_bits(32), store_ctl(4));
		end
		for (int i = 0; i < WORDS; i++) begin
			issue(mem_access_pkg::MEM_LOAD, make_addr(i[3:0], 2'd0), '0,
				load_ctl(mem_access_pkg::SIZE_WORD, 1'b0));
		end
		drain();
		finish_test();

		start_test("narrow_store");
		for (int i = 0; i < NARROW_STORES; i++) begin
			idx = stim_bits(4);
			if (i % 6 < 4) begin
				a = make_addr(idx[3:0], 2'(i % 6));
				issue(mem_access_pkg::MEM_STORE, a, stim_bits(32), store_ctl(1));
			end else begin
				a = make_addr(idx[3:0], 2'((i % 6 - 4) * 2));
				issue(mem_access_pkg::MEM_STORE, a, stim_bits(32), store_ctl(2));
			end
		end
		for (int i = 0; i < WORDS; i++) begin
			issue(mem_access_pkg::MEM_LOAD, make_addr(i[3:0], 2'd0), '0,
				load_ctl(mem_access_pkg::SIZE_WORD, 1'b0));
		end
		drain();
		finish_test();

		start_test("narrow_load");
		for (int rep = 0; rep < LOAD_REPS; rep++) begin
			for (int off = 0; off < 4; off++) begin
				for (int u = 0; u < 2; u++) begin
					idx = stim_bits(4);
					issue(mem_access_pkg::MEM_LOAD, make_addr(idx[3:0], 2'(off)), '0,
						load_ctl(mem_access_pkg::SIZE_BYTE, u[0]));
				end
			end
			for (int off = 0; off < 4; off += 2) begin
				for (int u = 0; u < 2; u++) begin
					idx = stim_bits(4);
					issue(mem_access_pkg::MEM_LOAD, make_addr(idx[3:0], 2'(off)), '0,
						load_ctl(mem_access_pkg::SIZE_HALF, u[0]));
				end
			end
		end
		drain();
		finish_test();

		// a no-op carries a full store mask but must not write
		start_test("no_op");
		for (int i = 0; i < NOOP_COUNT; i++) begin
			idx = stim_bits(4);
			a   = make_addr(idx[3:0], 2'd0);
			issue(mem_access_pkg::MEM_NONE, a, stim_bits(32), store_ctl(4));
			issue(mem_access_pkg::MEM_LOAD, a, '0, load_ctl(mem_access_pkg::SIZE_WORD, 1'b0));
		end
		drain();
		finish_test();

		start_test("random_backpressure");
		stall_enable = 1'b1;
		res_start    = results_seen;
		req_start    = requests_accepted;
		for (int i = 0; i < RANDOM_REQUESTS; i++) begin
			random_request();
		end
		drain();
		stall_enable = 1'b0;
		r = results_seen - res_start;
		assert (r == requests_accepted - req_start) else begin
			$display("%s: %0d results for %0d requests", cur_test, r,
				requests_accepted - req_start);
			note_error();
		end
		finish_test();

		$display("%0d tests, %0d failed, %0d errors, %0d requests, %0d results",
			tests_run, tests_failed, total_errors, requests_accepted, results_seen);
		if (total_errors == 0 && tests_failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tests/mem_stage_properties.sv */
// memory stage handshake properties
`timescale 1ns/1ps
`include "memu_config.svh"

module mem_stage_properties (
	input logic                        clk,
	input logic                        reset,
	input logic                        in_ready,
	input logic                        out_valid,
	input logic                        out_ready,
	input logic [`MEMU_DATA_WIDTH-1:0] out_rdata,
	input logic                        arvalid,
	input logic                        arready,
	input logic                        rready,
	input logic                        awvalid,
	input logic                        awready,
	input logic                        wvalid,
	input logic                        bready
);

	// result held under back-pressure
	out_held: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_rdata))
		else $error("out_valid or out_rdata changed while out_ready was low");

	ar_held: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	// write address and data travel together
	aw_held: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid && wvalid)
		else $error("awvalid or wvalid dropped before awready");

	no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid were high together");

	reset_state: assert property (@(posedge clk)
		reset |=> in_ready && !out_valid && !arvalid && !rready && !awvalid && !wvalid && !bready)
		else $error("handshake outputs not in their reset state");

endmodule

bind memu mem_stage_properties u_properties (
	.clk       (clk),
	.reset     (reset),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_rdata (out_rdata),
	.arvalid   (arvalid),
	.arready   (arready),
	.rready    (rready),
	.awvalid   (awvalid),
	.awready   (awready),
	.wvalid    (wvalid),
	.bready    (bready)
);

/* design/mem_stage_top.sv */
// memory stage top level
`timescale 1ns/1ps
`include "memu_config.svh"

module mem_stage_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  mem_access_pkg::mem_op_e     op,
	input  logic [`MEMU_ADDR_WIDTH-1:0] addr,
	input  logic [`MEMU_DATA_WIDTH-1:0] wdata,
	input  mem_access_pkg::mem_ctl_u    ctl,
	output logic                        out_valid,
	input  logic                        out_ready,
	output logic [`MEMU_DATA_WIDTH-1:0] out_rdata
);

	logic [`MEMU_ADDR_WIDTH-1:0]   araddr;
	logic [`MEMU_ADDR_WIDTH-1:0]   awaddr;
	logic [`MEMU_DATA_WIDTH-1:0]   rdata;
	logic [`MEMU_DATA_WIDTH-1:0]   wdata_bus;
	logic [`MEMU_DATA_WIDTH/8-1:0] wstrb;
	logic                          arvalid;
	logic                          arready;
	logic                          rvalid;
	logic                          rready;
	logic                          awvalid;
	logic                          awready;
	logic                          wvalid;
	logic                          wready;
	logic                          bvalid;
	logic                          bready;
	axi_lite_pkg::axi_resp_e       bresp;

	memu u_memu (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.ctl       (ctl),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rdata (out_rdata),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rvalid    (rvalid),
		.rready    (rready),
		.rdata     (rdata),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata_bus (wdata_bus),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bvalid    (bvalid),
		.bready    (bready),
		.bresp     (bresp)
	);

	axi_lite_sram u_sram (
		.clk     (clk),
		.reset   (reset),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata_bus),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp)
	);

endmodule

/* design/memu.sv */
// memory stage controller
`timescale 1ns/1ps
`include "memu_config.svh"

module memu (
	input  logic                         clk,
	input  logic                         reset,
	// from execute
	input  logic                         in_valid,
	output logic                         in_ready,
	input  mem_access_pkg::mem_op_e      op,
	input  logic [`MEMU_ADDR_WIDTH-1:0]  addr,
	input  logic [`MEMU_DATA_WIDTH-1:0]  wdata,
	input  mem_access_pkg::mem_ctl_u     ctl,
	// to write-back
	output logic                         out_valid,
	input  logic                         out_ready,
	output logic [`MEMU_DATA_WIDTH-1:0]  out_rdata,
	// read channels
	output logic [`MEMU_ADDR_WIDTH-1:0]  araddr,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic                         rvalid,
	output logic                         rready,
	input  logic [`MEMU_DATA_WIDTH-1:0]  rdata,
	// write channels
	output logic [`MEMU_ADDR_WIDTH-1:0]  awaddr,
	output logic                         awvalid,
	input  logic                         awready,
	output logic [`MEMU_DATA_WIDTH-1:0]  wdata_bus,
	output logic [`MEMU_DATA_WIDTH/8-1:0] wstrb,
	output logic                         wvalid,
	input  logic                         wready,
	input  logic                         bvalid,
	output logic                         bready,
	input  axi_lite_pkg::axi_resp_e      bresp
);

	localparam int AW = `MEMU_ADDR_WIDTH;
	localparam int DW = `MEMU_DATA_WIDTH;

	axi_lite_pkg::memu_state_e state;
	mem_access_pkg::mem_op_e   op_q;
	mem_access_pkg::mem_ctl_u  ctl_q;
	logic [AW-1:0]             addr_q;
	logic [AW-1:0]             word_addr;
	logic [DW-1:0]             wdata_q;
	logic [DW-1:0]             rdata_q;
	logic [DW-1:0]             load_value;
	logic [1:0]                offset;

	// locked request payload
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			addr_q  <= addr;
			wdata_q <= wdata;
			ctl_q   <= ctl;
		end
		if (state == axi_lite_pkg::READ_DATA && rvalid) begin
			rdata_q <= rdata;
		end
	end

	// word aligned bus address, low bits kept as byte offset
	assign offset    = addr_q[1:0];
	assign word_addr = {addr_q[AW-1:2], 2'b00};
	assign araddr    = word_addr;
	assign awaddr    = word_addr;

	// store lanes moved up to the byte offset
	assign wstrb     = ctl_q.mask << offset;
	assign wdata_bus = wdata_q << {offset, 3'b000};

	load_align u_load_align (
		.raw    (rdata_q),
		.offset (offset),
		.ctl    (ctl_q),
		.value  (load_value)
	);

	// stores and no-ops return zero
	assign out_rdata = (op_q == mem_access_pkg::MEM_LOAD) ? load_value : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= axi_lite_pkg::IDLE;
			op_q      <= mem_access_pkg::MEM_NONE;
			in_ready  <= 1'b1;
			out_valid <= 1'b0;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			bready    <= 1'b0;
		end else begin
			case (state)
				axi_lite_pkg::IDLE: begin
					if (in_valid && in_ready) begin
						in_ready <= 1'b0;
						op_q     <= op;
						case (op)
							mem_access_pkg::MEM_LOAD: begin
								arvalid <= 1'b1;
								state   <= axi_lite_pkg::READ_ADDR;
							end
							mem_access_pkg::MEM_STORE: begin
								// address and data go out together
								awvalid <= 1'b1;
								wvalid  <= 1'b1;
								state   <= axi_lite_pkg::WRITE_ADDR;
							end
							default: state <= axi_lite_pkg::DONE;
						endcase
					end
				end
				axi_lite_pkg::READ_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= axi_lite_pkg::READ_DATA;
					end
				end
				axi_lite_pkg::READ_DATA: begin
					if (rvalid) begin
						rready <= 1'b0;
						state  <= axi_lite_pkg::DONE;
					end
				end
				axi_lite_pkg::WRITE_ADDR: begin
					// sram raises both readies in the same cycle
					if (awready && wready) begin
						awvalid <= 1'b0;
						wvalid  <= 1'b0;
						bready  <= 1'b1;
						state   <= axi_lite_pkg::WRITE_RESP;
					end
				end
				axi_lite_pkg::WRITE_RESP: begin
					if (bvalid) begin
						bready <= 1'b0;
						if (bresp == axi_lite_pkg::OKAY) begin
							state <= axi_lite_pkg::DONE;
						end else begin
							// reissue the write on an error response
							awvalid <= 1'b1;
							wvalid  <= 1'b1;
							state   <= axi_lite_pkg::WRITE_ADDR;
						end
					end
				end
				axi_lite_pkg::DONE: begin
					// one cycle here before the result is offered
					if (!out_valid) begin
						out_valid <= 1'b1;
					end else if (out_ready) begin
						out_valid <= 1'b0;
						in_ready  <= 1'b1;
						state     <= axi_lite_pkg::IDLE;
					end
				end
				default: state <= axi_lite_pkg::IDLE;
			endcase
		end
	end

endmodule

/* design/axi_lite_sram.sv */
// axi-lite word sram
`timescale 1ns/1ps
`include "memu_config.svh"

module axi_lite_sram (
	input  logic                          clk,
	input  logic                          reset,
	// read channels
	input  logic [`MEMU_ADDR_WIDTH-1:0]   araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic                          rvalid,
	input  logic                          rready,
	output logic [`MEMU_DATA_WIDTH-1:0]   rdata,
	// write channels
	input  logic [`MEMU_ADDR_WIDTH-1:0]   awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [`MEMU_DATA_WIDTH-1:0]   wdata,
	input  logic [`MEMU_DATA_WIDTH/8-1:0] wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic                          bvalid,
	input  logic                          bready,
	output axi_lite_pkg::axi_resp_e       bresp
);

	localparam int DW    = `MEMU_DATA_WIDTH;
	localparam int SW    = DW / 8;
	localparam int IDX_W = $clog2(`MEMU_SRAM_WORDS);
	localparam int CNT_W = $clog2(`MEMU_SRAM_WAIT + 1);

	logic [DW-1:0]    mem [0:`MEMU_SRAM_WORDS-1];
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             rd_pend;
	logic             wait_done;
	logic             ar_hs;
	logic             r_hs;
	logic             w_hs;
	logic             b_hs;
	logic             ar_wait;
	logic             r_wait;
	logic             w_wait;

	assign wr_idx = awaddr[IDX_W+1:2];

	assign ar_hs = arvalid && arready;
	assign r_hs  = rvalid && rready;
	assign w_hs  = awvalid && awready && wvalid && wready;
	assign b_hs  = bvalid && bready;

	// phases that sit out the wait
	assign ar_wait   = arvalid && !arready;
	assign r_wait    = rd_pend && rready && !rvalid;
	assign w_wait    = awvalid && wvalid && !awready;
	assign wait_done = (wait_cnt == CNT_W'(`MEMU_SRAM_WAIT - 1));

	// always answers OKAY
	assign bresp = axi_lite_pkg::OKAY;

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
			rd_pend  <= 1'b0;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
		end else begin
			if (ar_wait || r_wait || w_wait) begin
				wait_cnt <= wait_done ? '0 : wait_cnt + 1'b1;
			end
			// readies are single-cycle pulses
			arready <= ar_wait && wait_done;
			awready <= w_wait && wait_done;
			wready  <= w_wait && wait_done;
			if (ar_hs) begin
				rd_pend <= 1'b1;
			end else if (r_wait && wait_done) begin
				rd_pend <= 1'b0;
			end
			if (r_wait && wait_done) begin
				rvalid <= 1'b1;
			end else if (r_hs) begin
				rvalid <= 1'b0;
			end
			// response one cycle after the write
			if (w_hs) begin
				bvalid <= 1'b1;
			end else if (b_hs) begin
				bvalid <= 1'b0;
			end
		end
	end

	// array and read word
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_idx <= araddr[IDX_W+1:2];
		end
		if (r_wait && wait_done) begin
			rdata <= mem[rd_idx];
		end
		if (w_hs) begin
			for (int i = 0; i < SW; i++) begin
				if (wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

endmodule

/* design/load_align.sv */
// load data alignment and extension
`timescale 1ns/1ps
`include "memu_config.svh"

module load_align (
	input  logic [`MEMU_DATA_WIDTH-1:0] raw,
	input  logic [1:0]                  offset,
	input  mem_access_pkg::mem_ctl_u    ctl,
	output logic [`MEMU_DATA_WIDTH-1:0] value
);

	localparam int DW = `MEMU_DATA_WIDTH;

	logic [DW-1:0] shifted;
	logic          is_unsigned;

	// bring the addressed byte down to lane 0
	assign shifted     = raw >> {offset, 3'b000};
	assign is_unsigned = ctl.load.is_unsigned;

	always_comb begin
		case (ctl.load.size)
			mem_access_pkg::SIZE_BYTE: begin
				if (is_unsigned) begin
					value = {{(DW-8){1'b0}}, shifted[7:0]};
				end else begin
					value = {{(DW-8){shifted[7]}}, shifted[7:0]};
				end
			end
			mem_access_pkg::SIZE_HALF: begin
				if (is_unsigned) begin
					value = {{(DW-16){1'b0}}, shifted[15:0]};
				end else begin
					value = {{(DW-16){shifted[15]}}, shifted[15:0]};
				end
			end
			// full word, no extension
			default: value = shifted;
		endcase
	end

endmodule

/* design/axi_lite_pkg.sv */
// bus side types
package axi_lite_pkg;

	// memory stage controller states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		READ_ADDR  = 3'd1,
		READ_DATA  = 3'd2,
		WRITE_ADDR = 3'd3,
		WRITE_RESP = 3'd4,
		DONE       = 3'd5
	} memu_state_e;

	// write response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

endpackage

/* design/mem_access_pkg.sv */
// memory access types
package mem_access_pkg;

	// operation handed over by execute
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_op_e;

	// size field of a load
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} load_size_e;

	// load view of the control nibble
	typedef struct packed {
		logic       is_unsigned;
		load_size_e size;
		logic       pad;
	} load_ctl_t;

	// one nibble, meaning set by the operation
	// store: byte mask at offset 0 (0001 byte, 0011 half, 1111 word)
	typedef union packed {
		logic [3:0] mask;
		load_ctl_t  load;
	} mem_ctl_u;

endpackage

/* design/memu_config.svh */
// memory stage configuration
`ifndef MEMU_CONFIG_SVH
`define MEMU_CONFIG_SVH

// byte address width
`define MEMU_ADDR_WIDTH 32

// data word width
`define MEMU_DATA_WIDTH 32

// sram depth in words, indexed by address bits 9 to 2
`define MEMU_SRAM_WORDS 256

// cycles the sram waits before raising a ready or valid
`define MEMU_SRAM_WAIT 2

`endif
